//--- common/eeprom_pkg.sv
package eeprom_pkg;

    // 24C16 organisation: 8 blocks of 256 bytes
    localparam int ADDR_W = 11;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        data_t;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // single bus operations handed to the bit engine
    typedef enum logic [1:0] {
        CMD_START, // repeated start when the bus is already held
        CMD_STOP,
        CMD_WRITE, // 8 bits out, then sample slave ack
        CMD_READ   // 8 bits in, then drive master ack
    } bus_cmd_t;

    localparam int CLK_DIV_DEF = 2; // CLK cycles per quarter SCL period

endpackage

//--- eeprom_ctrl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = eeprom_pkg::CLK_DIV_DEF
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_go,
    input  eeprom_pkg::bus_cmd_t cmd,
    input  eeprom_pkg::data_t    tx_byte,
    input  logic                 ack_out,
    output logic                 cmd_done,
    output eeprom_pkg::data_t    rx_byte,
    output logic                 ack_in,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic             active;
    bus_cmd_t         cur_cmd;
    logic [DIV_W-1:0] div_cnt;  // cycles within a quarter
    logic [5:0]       qcnt;     // quarter index, bit = qcnt[5:2]
    logic [8:0]       shreg;
    logic             tick;
    logic             is_byte;
    logic             last_q;
    logic [1:0]       nq;

    assign tick     = active && (div_cnt == DIV_LAST);
    assign is_byte  = (cur_cmd == CMD_WRITE) || (cur_cmd == CMD_READ);
    assign last_q   = is_byte ? (qcnt == 6'd35) : (qcnt == 6'd3);
    assign nq       = qcnt[1:0] + 2'd1; // quarter about to begin
    assign cmd_done = tick && last_q;

    // after 9 shifts: sampled byte on top, ack slot in bit 0
    assign rx_byte = shreg[8:1];
    assign ack_in  = shreg[0];

    // outputs are registered one quarter ahead, at each tick
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            cur_cmd <= CMD_STOP;
            div_cnt <= '0;
            qcnt    <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else if (cmd_go)
        begin
            active  <= 1'b1;
            cur_cmd <= cmd;
            div_cnt <= '0;
            qcnt    <= '0;
            scl     <= 1'b0; // every command opens with SCL low
            if (cmd == CMD_START)
                sda_oe <= 1'b0;
            else if (cmd == CMD_STOP)
                sda_oe <= 1'b1;
        end
        else if (tick)
        begin
            div_cnt <= '0;
            if (last_q)
            begin
                active <= 1'b0;
                if (is_byte)
                    scl <= 1'b0; // park low, bus still owned
            end
            else
            begin
                qcnt <= qcnt + 6'd1;
                case (cur_cmd)
                    CMD_START:
                    begin
                        // SDA falls while SCL high, then SCL drops
                        scl    <= (nq != 2'd3);
                        sda_oe <= nq[1];
                    end
                    CMD_STOP:
                    begin
                        scl    <= 1'b1;
                        sda_oe <= (nq == 2'd1); // release in q2 -> stop
                    end
                    default:
                    begin
                        scl <= nq[1];
                        if (nq == 2'd1)
                            sda_oe <= ~shreg[8]; // middle of low half
                    end
                endcase
            end
        end
        else if (active)
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // shared shifter for both directions, 9th bit is the ack slot
    always_ff @(posedge CLK)
    begin
        if (cmd_go && (cmd == CMD_WRITE))
            shreg <= {tx_byte, 1'b1};
        else if (cmd_go && (cmd == CMD_READ))
            shreg <= {8'hff, ack_out};
        else if (tick && is_byte && (qcnt[1:0] == 2'd2))
            shreg <= {shreg[7:0], sda_in}; // middle of high half
    end

endmodule

//--- eeprom_ctrl/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::addr_t    addr,
    input  eeprom_pkg::data_t    wdata,
    output eeprom_pkg::data_t    rdata,
    output logic                 done,
    output logic                 nack,
    output logic                 busy,
    output logic                 cmd_go,
    output eeprom_pkg::bus_cmd_t cmd,
    output eeprom_pkg::data_t    tx_byte,
    output logic                 ack_out,
    input  logic                 cmd_done,
    input  eeprom_pkg::data_t    rx_byte,
    input  logic                 ack_in
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RSTART,
        ST_CTRL_R,
        ST_READ,
        ST_STOP
    } state_t;

    state_t state;
    addr_t  addr_q;
    data_t  wdata_q;
    logic   is_rd;
    logic   err;     // some byte went unacknowledged
    logic   accept;

    assign accept  = (state == ST_IDLE) && (wr || rd);
    assign busy    = (state != ST_IDLE);
    assign ack_out = (state == ST_READ); // single-byte read ends with no-ack

    // command and byte follow the state, cmd_go marks the first cycle
    always_comb
    begin
        cmd     = CMD_STOP;
        tx_byte = '0;
        case (state)
            ST_START, ST_RSTART: cmd = CMD_START;
            ST_CTRL_W:
            begin
                cmd     = CMD_WRITE;
                tx_byte = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b0};
            end
            ST_ADDR:
            begin
                cmd     = CMD_WRITE;
                tx_byte = addr_q[7:0];
            end
            ST_DATA:
            begin
                cmd     = CMD_WRITE;
                tx_byte = wdata_q;
            end
            ST_CTRL_R:
            begin
                cmd     = CMD_WRITE;
                tx_byte = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b1};
            end
            ST_READ: cmd = CMD_READ;
            default: cmd = CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= ST_IDLE;
            cmd_go <= 1'b0;
            done   <= 1'b0;
            nack   <= 1'b0;
            err    <= 1'b0;
            is_rd  <= 1'b0;
        end
        else
        begin
            cmd_go <= 1'b0;
            done   <= 1'b0;
            case (state)
                ST_IDLE:
                    if (accept)
                    begin
                        is_rd  <= ~wr; // wr wins a tie
                        err    <= 1'b0;
                        state  <= ST_START;
                        cmd_go <= 1'b1;
                    end
                ST_START:
                    if (cmd_done)
                    begin
                        state  <= ST_CTRL_W;
                        cmd_go <= 1'b1;
                    end
                ST_CTRL_W, ST_CTRL_R, ST_ADDR:
                    if (cmd_done)
                    begin
                        cmd_go <= 1'b1;
                        if (ack_in)
                        begin
                            err   <= 1'b1;
                            state <= ST_STOP;
                        end
                        else if (state == ST_CTRL_R)
                            state <= ST_READ;
                        else if (state == ST_CTRL_W)
                            state <= ST_ADDR;
                        else
                            state <= is_rd ? ST_RSTART : ST_DATA;
                    end
                ST_DATA:
                    if (cmd_done)
                    begin
                        err    <= ack_in;
                        state  <= ST_STOP;
                        cmd_go <= 1'b1;
                    end
                ST_RSTART:
                    if (cmd_done)
                    begin
                        state  <= ST_CTRL_R;
                        cmd_go <= 1'b1;
                    end
                ST_READ:
                    if (cmd_done)
                    begin
                        state  <= ST_STOP;
                        cmd_go <= 1'b1;
                    end
                ST_STOP:
                    if (cmd_done)
                    begin
                        done  <= 1'b1;
                        nack  <= err;
                        state <= ST_IDLE;
                    end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if ((state == ST_READ) && cmd_done)
            rdata <= rx_byte; // held until the next read
    end

endmodule

//--- src/eeprom_if_top.sv
`timescale 1ns/1ps

module eeprom_if_top #(
    parameter int CLK_DIV = eeprom_pkg::CLK_DIV_DEF
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wdata,
    output eeprom_pkg::data_t rdata,
    output logic              done,
    output logic              nack,
    output logic              busy,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);
    import eeprom_pkg::*;

    logic     cmd_go;
    bus_cmd_t cmd;
    data_t    tx_byte;
    logic     ack_out;
    logic     cmd_done;
    data_t    rx_byte;
    logic     ack_in;

    // transaction level
    eeprom_sequencer seq0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .done     (done),
        .nack     (nack),
        .busy     (busy),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .ack_out  (ack_out),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .ack_in   (ack_in)
    );

    // bit level, owns the pins
    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) eng0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .ack_out  (ack_out),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .ack_in   (ack_in),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

//--- tests/eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic       CLK,
    input  logic       scl,
    input  logic       sda,
    input  logic       refuse_en,
    input  logic [2:0] refuse_blk,
    output logic       sda_pull
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_CTRL,
        SL_ADDR,
        SL_WDATA,
        SL_RD
    } slave_st_t;

    data_t      mem [0:2047];
    slave_st_t  st;
    addr_t      ptr;
    data_t      sh;
    data_t      txs;       // read byte, next bit on top
    logic [3:0] bcnt;      // rising edges since start or last ack
    logic       prev_scl;
    logic       prev_sda;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ {5'b0, i[10:8]}; // power-up pattern
        st       = SL_IDLE;
        bcnt     = '0;
        sda_pull = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
    end

    // both lines oversampled with the system clock
    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (scl && prev_scl && prev_sda && !sda)
        begin
            st       <= SL_CTRL; // start or repeated start
            bcnt     <= '0;
            sda_pull <= 1'b0;
        end
        else if (scl && prev_scl && !prev_sda && sda)
        begin
            st       <= SL_IDLE;
            sda_pull <= 1'b0;
        end
        else if (st == SL_IDLE)
            sda_pull <= 1'b0;
        else if (scl && !prev_scl)
        begin
            if (bcnt < 4'd8)
            begin
                sh   <= {sh[6:0], sda};
                bcnt <= bcnt + 4'd1;
            end
            else
            begin
                bcnt <= 4'd9;
                if ((st == SL_RD) && sda)
                    st <= SL_IDLE; // master no-ack ends the read
            end
        end
        else if (!scl && prev_scl)
        begin
            if (bcnt == 4'd8)
            begin
                case (st)
                    SL_CTRL:
                        if ((sh[7:4] == DEV_CODE) && !(refuse_en && (sh[3:1] == refuse_blk)))
                        begin
                            sda_pull  <= 1'b1;
                            ptr[10:8] <= sh[3:1];
                            st        <= sh[0] ? SL_RD : SL_ADDR;
                        end
                        else
                            st <= SL_IDLE; // stay off the bus
                    SL_ADDR:
                    begin
                        sda_pull <= 1'b1;
                        ptr[7:0] <= sh;
                        st       <= SL_WDATA;
                    end
                    SL_WDATA:
                    begin
                        sda_pull <= 1'b1;
                        mem[ptr] <= sh;
                    end
                    default: sda_pull <= 1'b0; // master owns the ack slot
                endcase
            end
            else if (bcnt == 4'd9)
            begin
                bcnt     <= '0;
                sda_pull <= (st == SL_RD) && !mem[ptr][7];
                txs      <= {mem[ptr][6:0], 1'b0};
            end
            else if ((st == SL_RD) && (bcnt != 4'd0))
            begin
                sda_pull <= !txs[7];
                txs      <= {txs[6:0], 1'b0};
            end
        end
    end

endmodule

//--- tests/tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom;
    import eeprom_pkg::*;

    localparam int TIMEOUT = 2000; // well above the ~330 cycles of a read

    logic       CLK;
    logic       RESET;
    logic       wr;
    logic       rd;
    addr_t      addr;
    data_t      wdata;
    data_t      rdata;
    logic       done;
    logic       nack;
    logic       busy;
    logic       scl;
    logic       sda_oe;
    logic       sda_in;
    logic       slave_pull;
    logic       refuse_en;
    logic [2:0] refuse_blk;
    data_t      shadow [0:2047];
    logic       written [0:2047];
    logic       exp_read;  // what the next done has to show
    logic       exp_nack;
    data_t      exp_data;

    assign sda_in = !(sda_oe || slave_pull); // open drain with pull-up

    eeprom_if_top #(
        .CLK_DIV (2)
    ) dut0 (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .done   (done),
        .nack   (nack),
        .busy   (busy),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    eeprom_slave_model slave0 (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda_in),
        .refuse_en  (refuse_en),
        .refuse_blk (refuse_blk),
        .sda_pull   (slave_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failed check");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // shadow of acknowledged writes or the power-up fill
    function automatic data_t expected_byte(input addr_t a);
        if (written[a])
            return shadow[a];
        return a[7:0] ^ {5'b0, a[10:8]};
    endfunction

    always @(posedge CLK)
    begin
        if (done)
        begin
            check_flag("nack", nack, exp_nack);
            if (exp_read && !exp_nack)
                check_data("rdata", rdata, exp_data);
        end
    end

    task automatic wait_done();
        int n;
        n = 0;
        @(posedge CLK);
        while (!done)
        begin
            if (n == TIMEOUT)
            begin
                $display("timeout, no done within %0d cycles", TIMEOUT);
                abort_run();
            end
            n++;
            @(posedge CLK);
        end
    endtask

    task automatic pulse_request(input logic is_wr, input addr_t a, input data_t d);
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic write_byte(input addr_t a, input data_t d, input logic refused);
        exp_read <= 1'b0;
        exp_nack <= refused;
        pulse_request(1'b1, a, d);
        wait_done();
        if (!refused)
        begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic read_byte(input addr_t a, input logic refused);
        exp_read <= 1'b1;
        exp_nack <= refused;
        exp_data <= expected_byte(a);
        pulse_request(1'b0, a, 8'h00);
        wait_done();
    endtask

    initial
    begin
        addr_t a;
        data_t d;
        int    n;
        void'($urandom(59706));
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        refuse_en  = 1'b0;
        refuse_blk = '0;
        exp_read   = 1'b0;
        exp_nack   = 1'b0;
        exp_data   = '0;
        for (int i = 0; i < 2048; i++)
        begin
            shadow[i]  = '0;
            written[i] = 1'b0;
        end
        RESET = 1'b1;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);

        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("done", done, 1'b0);

        // i % 8 walks all blocks
        for (int i = 0; i < 20; i++)
        begin
            a = {3'(i % 8), 8'($urandom)};
            d = data_t'($urandom);
            write_byte(a, d, 1'b0);
            read_byte(a, 1'b0);
        end

        a = addr_t'($urandom);
        while (written[a])
            a = a + 11'd1;
        read_byte(a, 1'b0);

        // block 5 refused by the slave
        a = {3'd5, 8'($urandom)};
        @(posedge CLK);
        refuse_en  <= 1'b1;
        refuse_blk <= 3'd5;
        write_byte(a, ~expected_byte(a), 1'b1);
        read_byte(a, 1'b1);
        @(posedge CLK);
        refuse_en <= 1'b0;
        read_byte(a, 1'b0);

        a        = addr_t'($urandom);
        d        = data_t'($urandom);
        exp_read <= 1'b0;
        exp_nack <= 1'b0;
        pulse_request(1'b1, a, d);
        @(posedge CLK);
        check_flag("busy", busy, 1'b1);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= ~d;
        @(posedge CLK);
        wr <= 1'b0;
        wait_done();
        shadow[a]  = d;
        written[a] = 1'b1;
        n = 0;
        while (n < TIMEOUT)
        begin
            @(posedge CLK);
            if (done)
            begin
                $display("a request made while busy produced a second done");
                abort_run();
            end
            n++;
        end
        read_byte(a, 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
common/eeprom_pkg.sv
eeprom_ctrl/i2c_bit_engine.sv
eeprom_ctrl/eeprom_sequencer.sv
src/eeprom_if_top.sv
tests/eeprom_slave_model.sv
tests/tb_eeprom.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_eeprom -f list.f
out=$(./obj_dir/Vtb_eeprom 2>&1) || true
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
